// File: logic/packer_defs.svh
// Width and depth constants shared by the packer RTL
// Word, segment length and fill widths, component FIFO sizing

`ifndef PACKER_DEFS_SVH
`define PACKER_DEFS_SVH

// Code word and output word width
`define WORD_BITS 32

// Segment length, 1 to 32
`define COUNT_BITS 6

// Bit offset inside the current word
`define FILL_BITS 5

// Component FIFO sizing
`define FIFO_DEPTH 16
`define FIFO_ADDR_BITS 4

`endif

// File: logic/bitstream_pkg.sv
// Bitstream types: code word, segment bit count, word fill offset

`default_nettype none

`include "packer_defs.svh"

package bitstream_pkg;

    // Code bits, MSB first, valid bits left-justified
    typedef logic [`WORD_BITS-1:0] code_word_t;

    // Segment length in bits
    typedef logic [`COUNT_BITS-1:0] bit_count_t;

    // Next free bit in the unfinished word
    typedef logic [`FILL_BITS-1:0] fill_t;

endpackage

`default_nettype wire

// File: logic/component_pkg.sv
// Colour component enumeration and block order successor

`default_nettype none

package component_pkg;

    typedef enum logic [1:0] {
        COMP_Y  = 2'd0,
        COMP_CB = 2'd1,
        COMP_CR = 2'd2
    } component_e;

    // Block order Y, Cb, Cr, then back to Y
    function automatic component_e next_component(input component_e comp);
        case (comp)
            COMP_Y:  return COMP_CB;
            COMP_CB: return COMP_CR;
            default: return COMP_Y;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: logic/segment_fifo.sv
// Show-ahead synchronous FIFO of tagged code segments, one per component

`timescale 1ns/10ps
`default_nettype none

`include "packer_defs.svh"

module segment_fifo #(
    parameter int DEPTH = `FIFO_DEPTH
) (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       wr,
    input  wire bitstream_pkg::code_word_t wr_data,
    input  wire bitstream_pkg::bit_count_t wr_length,
    input  wire                       wr_eob,
    input  wire                       pop,
    output bitstream_pkg::code_word_t head_data,
    output bitstream_pkg::bit_count_t head_length,
    output logic                      head_eob,
    output logic                      empty
);
    import bitstream_pkg::*;

    localparam int ADDR_BITS = $clog2(DEPTH);

    code_word_t           data_mem [DEPTH];
    bit_count_t           length_mem [DEPTH];
    logic [DEPTH-1:0]     eob_mem;
    logic [ADDR_BITS-1:0] wr_ptr;
    logic [ADDR_BITS-1:0] rd_ptr;
    logic [ADDR_BITS:0]   count;
    logic                 full;

    assign empty = (count == '0);
    assign full  = (count == (ADDR_BITS + 1)'(DEPTH));

    // Head is visible without a read cycle
    assign head_data   = data_mem[rd_ptr];
    assign head_length = length_mem[rd_ptr];
    assign head_eob    = eob_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            data_mem[wr_ptr]   <= wr_data;
            length_mem[wr_ptr] <= wr_length;
            eob_mem[wr_ptr]    <= wr_eob;
        end
    end

    // Input side has no ready, so a full FIFO means lost segments
    a_no_overflow: assert property (@(posedge clk) disable iff (rst) wr |-> !full || pop)
        else $error("segment written into a full FIFO");
    a_no_underflow: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else $error("pop from an empty FIFO");

endmodule

`default_nettype wire

// File: logic/block_sequencer.sv
// Block sequencer draining the Y, Cb and Cr FIFOs in block order
// Registers the selected head toward the aligner

`timescale 1ns/10ps
`default_nettype none

module block_sequencer (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            empty_y,
    input  wire                            empty_cb,
    input  wire                            empty_cr,
    input  wire bitstream_pkg::code_word_t head_data_y,
    input  wire bitstream_pkg::code_word_t head_data_cb,
    input  wire bitstream_pkg::code_word_t head_data_cr,
    input  wire bitstream_pkg::bit_count_t head_length_y,
    input  wire bitstream_pkg::bit_count_t head_length_cb,
    input  wire bitstream_pkg::bit_count_t head_length_cr,
    input  wire                            head_eob_y,
    input  wire                            head_eob_cb,
    input  wire                            head_eob_cr,
    output logic                           pop_y,
    output logic                           pop_cb,
    output logic                           pop_cr,
    output logic                           in_valid,
    output bitstream_pkg::code_word_t      in_data,
    output bitstream_pkg::bit_count_t      in_length,
    output logic                           in_eob
);
    import bitstream_pkg::*;
    import component_pkg::*;

    component_e cur;
    code_word_t sel_data;
    bit_count_t sel_length;
    logic       sel_eob;
    logic       sel_empty;
    logic       take;

    always_comb begin
        case (cur)
            COMP_CB: begin
                sel_data   = head_data_cb;
                sel_length = head_length_cb;
                sel_eob    = head_eob_cb;
                sel_empty  = empty_cb;
            end
            COMP_CR: begin
                sel_data   = head_data_cr;
                sel_length = head_length_cr;
                sel_eob    = head_eob_cr;
                sel_empty  = empty_cr;
            end
            default: begin
                sel_data   = head_data_y;
                sel_length = head_length_y;
                sel_eob    = head_eob_y;
                sel_empty  = empty_y;
            end
        endcase
    end

    // Waits on the current component even if others hold data
    assign take   = !sel_empty;
    assign pop_y  = take && (cur == COMP_Y);
    assign pop_cb = take && (cur == COMP_CB);
    assign pop_cr = take && (cur == COMP_CR);

    always_ff @(posedge clk) begin
        if (rst) begin
            cur      <= COMP_Y;
            in_valid <= 1'b0;
        end else begin
            in_valid <= take;
            if (take && sel_eob) begin
                cur <= next_component(cur);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            in_data   <= sel_data;
            in_length <= sel_length;
            in_eob    <= sel_eob;
        end
    end

endmodule

`default_nettype wire

// File: logic/segment_aligner.sv
// Segment aligner: running bit offset and five-stage barrel shift
// Splits each segment into the current-word part and the overflow part

`timescale 1ns/10ps
`default_nettype none

`include "packer_defs.svh"

module segment_aligner (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            in_valid,
    input  wire bitstream_pkg::code_word_t in_data,
    input  wire bitstream_pkg::bit_count_t in_length,
    output logic                           al_valid,
    output bitstream_pkg::code_word_t      hi_part,
    output bitstream_pkg::code_word_t      lo_part,
    output logic                           wrap,
    output bitstream_pkg::fill_t           fill_count
);
    import bitstream_pkg::*;

    localparam int STAGES = 5;

    fill_t            fill;
    bit_count_t       sum;
    code_word_t       masked;
    code_word_t [1:0] pair_in;
    code_word_t [1:0] pair_q [STAGES];
    fill_t            off_q [STAGES-1];
    logic [STAGES-1:0] valid_q;
    logic [STAGES-1:0] wrap_q;

    // Clear everything below the segment length
    assign masked  = in_data & ~(code_word_t'('1) >> in_length);
    assign pair_in = {masked, code_word_t'('0)};
    assign sum     = bit_count_t'(fill) + in_length;

    always_ff @(posedge clk) begin
        if (rst) begin
            fill    <= '0;
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[STAGES-2:0], in_valid};
            if (in_valid) begin
                fill <= fill_t'(sum);
            end
        end
    end

    // Stage k shifts by 16 >> k when offset bit 4-k is set
    always_ff @(posedge clk) begin
        pair_q[0] <= fill[STAGES-1] ? pair_in >> (`WORD_BITS / 2) : pair_in;
        wrap_q[0] <= (sum >= `WORD_BITS);
        off_q[0]  <= fill;
        for (int k = 1; k < STAGES; k++) begin
            pair_q[k] <= off_q[k-1][STAGES-1-k] ?
                         pair_q[k-1] >> ((`WORD_BITS / 2) >> k) : pair_q[k-1];
            wrap_q[k] <= wrap_q[k-1];
        end
        for (int k = 1; k < STAGES - 1; k++) begin
            off_q[k] <= off_q[k-1];
        end
    end

    assign al_valid   = valid_q[STAGES-1];
    assign hi_part    = pair_q[STAGES-1][1];
    assign lo_part    = pair_q[STAGES-1][0];
    assign wrap       = wrap_q[STAGES-1];
    assign fill_count = fill;

    // Zero-length segments would stall the offset without any output
    a_length_nonzero: assert property (@(posedge clk) disable iff (rst)
        in_valid |-> in_length != '0)
        else $error("segment of length zero reached the aligner");

endmodule

`default_nettype wire

// File: logic/word_assembler.sv
// Word assembler merging aligned segment parts into 32-bit output words

`timescale 1ns/10ps
`default_nettype none

module word_assembler (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            al_valid,
    input  wire bitstream_pkg::code_word_t hi_part,
    input  wire bitstream_pkg::code_word_t lo_part,
    input  wire                            wrap,
    output bitstream_pkg::code_word_t      word,
    output logic                           word_valid
);
    import bitstream_pkg::*;

    code_word_t acc;
    code_word_t merged;

    // Bits above the fill point already sit in acc
    assign merged = acc | hi_part;

    always_ff @(posedge clk) begin
        if (rst) begin
            acc        <= '0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= al_valid && wrap;
            if (al_valid) begin
                // Overflow bits start the next word
                acc <= wrap ? lo_part : merged;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (al_valid && wrap) begin
            word <= merged;
        end
    end

endmodule

`default_nettype wire

// File: logic/jpeg_stream_packer.sv
// JPEG entropy-stream packer top level
// Write steering into the component FIFOs, sequencer, aligner, assembler

`timescale 1ns/10ps
`default_nettype none

`include "packer_defs.svh"

module jpeg_stream_packer (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              seg_valid,
    input  wire component_pkg::component_e   seg_component,
    input  wire bitstream_pkg::code_word_t   seg_data,
    input  wire bitstream_pkg::bit_count_t   seg_length,
    input  wire                              seg_eob,
    output bitstream_pkg::code_word_t        word,
    output logic                             word_valid,
    output bitstream_pkg::fill_t             fill_count
);
    import bitstream_pkg::*;
    import component_pkg::*;

    localparam int SEG_FIFO_DEPTH = 1 << `FIFO_ADDR_BITS;

    logic       wr_y, wr_cb, wr_cr;
    logic       pop_y, pop_cb, pop_cr;
    logic       empty_y, empty_cb, empty_cr;
    code_word_t head_data_y, head_data_cb, head_data_cr;
    bit_count_t head_length_y, head_length_cb, head_length_cr;
    logic       head_eob_y, head_eob_cb, head_eob_cr;
    logic       in_valid;
    code_word_t in_data;
    bit_count_t in_length;
    logic       al_valid;
    code_word_t hi_part;
    code_word_t lo_part;
    logic       wrap;

    assign wr_y  = seg_valid && (seg_component == COMP_Y);
    assign wr_cb = seg_valid && (seg_component == COMP_CB);
    assign wr_cr = seg_valid && (seg_component == COMP_CR);

    segment_fifo #(.DEPTH(SEG_FIFO_DEPTH)) fifo_y (
        .clk(clk), .rst(rst),
        .wr(wr_y), .wr_data(seg_data), .wr_length(seg_length), .wr_eob(seg_eob),
        .pop(pop_y),
        .head_data(head_data_y), .head_length(head_length_y), .head_eob(head_eob_y),
        .empty(empty_y)
    );

    segment_fifo #(.DEPTH(SEG_FIFO_DEPTH)) fifo_cb (
        .clk(clk), .rst(rst),
        .wr(wr_cb), .wr_data(seg_data), .wr_length(seg_length), .wr_eob(seg_eob),
        .pop(pop_cb),
        .head_data(head_data_cb), .head_length(head_length_cb), .head_eob(head_eob_cb),
        .empty(empty_cb)
    );

    segment_fifo #(.DEPTH(SEG_FIFO_DEPTH)) fifo_cr (
        .clk(clk), .rst(rst),
        .wr(wr_cr), .wr_data(seg_data), .wr_length(seg_length), .wr_eob(seg_eob),
        .pop(pop_cr),
        .head_data(head_data_cr), .head_length(head_length_cr), .head_eob(head_eob_cr),
        .empty(empty_cr)
    );

    block_sequencer u_sequencer (
        .clk(clk), .rst(rst),
        .empty_y(empty_y), .empty_cb(empty_cb), .empty_cr(empty_cr),
        .head_data_y(head_data_y), .head_data_cb(head_data_cb),
        .head_data_cr(head_data_cr),
        .head_length_y(head_length_y), .head_length_cb(head_length_cb),
        .head_length_cr(head_length_cr),
        .head_eob_y(head_eob_y), .head_eob_cb(head_eob_cb), .head_eob_cr(head_eob_cr),
        .pop_y(pop_y), .pop_cb(pop_cb), .pop_cr(pop_cr),
        .in_valid(in_valid), .in_data(in_data), .in_length(in_length),
        .in_eob()
    );

    segment_aligner u_aligner (
        .clk(clk), .rst(rst),
        .in_valid(in_valid), .in_data(in_data), .in_length(in_length),
        .al_valid(al_valid), .hi_part(hi_part), .lo_part(lo_part), .wrap(wrap),
        .fill_count(fill_count)
    );

    word_assembler u_assembler (
        .clk(clk), .rst(rst),
        .al_valid(al_valid), .hi_part(hi_part), .lo_part(lo_part), .wrap(wrap),
        .word(word), .word_valid(word_valid)
    );

endmodule

`default_nettype wire

// File: bench/packer_tb.sv
// Directed testbench for the JPEG stream packer
// Bit-queue reference model in Y, Cb, Cr block order, word monitor, cycle limit

`timescale 1ns/10ps
`default_nettype none

module packer_tb;
    import bitstream_pkg::*;
    import component_pkg::*;

    // Three full FIFOs drained one per cycle, plus the aligner stages
    localparam int SETTLE_CYCLES = 60;

    // Order in which blocks leave the packer
    localparam component_e BLOCK_ORDER [3] = '{COMP_Y, COMP_CB, COMP_CR};

    logic       clk;
    logic       rst;
    logic       seg_valid;
    component_e seg_component;
    code_word_t seg_data;
    bit_count_t seg_length;
    logic       seg_eob;
    code_word_t word;
    logic       word_valid;
    fill_t      fill_count;

    logic        exp_bits [$];
    logic [38:0] pending [3][$];
    int          model_slot;
    int          total_bits;
    int          segs_sent;
    int          cycle_count;
    int          checks;
    int          errors;

    jpeg_stream_packer uut (
        .clk(clk), .rst(rst),
        .seg_valid(seg_valid), .seg_component(seg_component),
        .seg_data(seg_data), .seg_length(seg_length), .seg_eob(seg_eob),
        .word(word), .word_valid(word_valid), .fill_count(fill_count)
    );

    always #20 clk = ~clk;

    task automatic check_word(input code_word_t actual, input code_word_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL word: got %h, expected %h", actual, expected);
        end
    endtask

    task automatic check_fill(input fill_t actual, input fill_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL fill_count: got %h, expected %h", actual, expected);
        end
    endtask

    // Moves queued segments of the current component into the bit stream
    task automatic model_drain();
        logic [38:0] entry;
        int comp;
        int len;
        comp = int'(BLOCK_ORDER[model_slot]);
        while (pending[comp].size() > 0) begin
            entry = pending[comp].pop_front();
            len = int'(entry[37:32]);
            for (int i = 0; i < len; i++) begin
                exp_bits.push_back(entry[31 - i]);
            end
            total_bits += len;
            if (entry[38]) begin
                model_slot = (model_slot + 1) % 3;
                comp = int'(BLOCK_ORDER[model_slot]);
            end
        end
    endtask

    task automatic send_segment(input component_e comp, input code_word_t data,
                                input bit_count_t len, input logic eob);
        seg_valid     = 1'b1;
        seg_component = comp;
        seg_data      = data;
        seg_length    = len;
        seg_eob       = eob;
        pending[int'(comp)].push_back({eob, len, data});
        segs_sent++;
        model_drain();
        @(negedge clk);
        seg_valid = 1'b0;
        seg_eob   = 1'b0;
    endtask

    // One full-word Cb and Cr block so the sequencer is back on Y
    task automatic close_round();
        send_segment(COMP_CB, 32'h3C3C_A5A5, 6'd32, 1'b1);
        send_segment(COMP_CR, 32'h0F1E_2D3C, 6'd32, 1'b1);
    endtask

    task automatic wait_idle();
        while (exp_bits.size() >= 32) begin
            @(negedge clk);
        end
        repeat (SETTLE_CYCLES) @(negedge clk);
        check_fill(fill_count, fill_t'(total_bits));
    endtask

    task automatic after_reset_idle();
        repeat (8) @(negedge clk);
        check_fill(fill_count, fill_t'(0));
    endtask

    task automatic full_words_y();
        send_segment(COMP_Y, 32'h0123_4567, 6'd32, 1'b0);
        send_segment(COMP_Y, 32'h89AB_CDEF, 6'd32, 1'b0);
        send_segment(COMP_Y, 32'hFEDC_BA98, 6'd32, 1'b0);
        send_segment(COMP_Y, 32'h7654_3210, 6'd32, 1'b1);
        close_round();
        wait_idle();
    endtask

    task automatic boundary_lengths();
        int lens [5];
        lens = '{5, 13, 27, 19, 32};
        for (int i = 0; i < 5; i++) begin
            send_segment(COMP_Y, $urandom, bit_count_t'(lens[i]), i == 4);
        end
        close_round();
        wait_idle();
    endtask

    task automatic reversed_block_order();
        send_segment(COMP_CR, 32'hA5A5_1234, 6'd16, 1'b0);
        send_segment(COMP_CR, 32'hFFF0_0FFF, 6'd12, 1'b1);
        send_segment(COMP_CB, 32'h1234_5678, 6'd24, 1'b0);
        send_segment(COMP_CB, 32'h8000_0001, 6'd1, 1'b0);
        send_segment(COMP_CB, 32'hC0FF_EE00, 6'd3, 1'b1);
        send_segment(COMP_Y, 32'hDEAD_BEEF, 6'd32, 1'b0);
        send_segment(COMP_Y, 32'h7ABC_DEF0, 6'd4, 1'b1);
        wait_idle();
    endtask

    task automatic random_blocks();
        code_word_t blk_data [3][4];
        int blk_len [3][4];
        int blk_n [3];
        int sent [3];
        int left;
        int c;
        for (int round = 0; round < 3; round++) begin
            left = 0;
            for (int k = 0; k < 3; k++) begin
                blk_n[k] = $urandom_range(1, 4);
                sent[k] = 0;
                left += blk_n[k];
                for (int s = 0; s < blk_n[k]; s++) begin
                    blk_data[k][s] = $urandom;
                    blk_len[k][s] = $urandom_range(1, 32);
                end
            end
            // Components interleave at random, each keeps its own order
            while (left > 0) begin
                c = $urandom_range(0, 2);
                if (sent[c] < blk_n[c]) begin
                    send_segment(component_e'(c), blk_data[c][sent[c]],
                                 bit_count_t'(blk_len[c][sent[c]]),
                                 sent[c] == blk_n[c] - 1);
                    sent[c]++;
                    left--;
                end
            end
        end
        wait_idle();
    endtask

    // Word monitor against the next 32 expected bits
    always @(negedge clk) begin
        code_word_t expected;
        if (!rst && word_valid) begin
            if (exp_bits.size() < 32) begin
                errors++;
                $display("word emitted with only %0d expected bits pending", exp_bits.size());
            end else begin
                for (int i = 0; i < 32; i++) begin
                    expected[31 - i] = exp_bits.pop_front();
                end
                check_word(word, expected);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > 40 * segs_sent + 200) begin
            $display("timeout after %0d cycles with %0d expected bits pending",
                     cycle_count, exp_bits.size());
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h0989_b363));
        clk           = 1'b0;
        rst           = 1'b1;
        seg_valid     = 1'b0;
        seg_component = COMP_Y;
        seg_data      = '0;
        seg_length    = '0;
        seg_eob       = 1'b0;
        model_slot    = 0;
        total_bits    = 0;
        segs_sent     = 0;
        cycle_count   = 0;
        checks        = 0;
        errors        = 0;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        after_reset_idle();
        full_words_y();
        boundary_lengths();
        reversed_block_order();
        random_blocks();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+logic
logic/bitstream_pkg.sv
logic/component_pkg.sv
logic/segment_fifo.sv
logic/block_sequencer.sv
logic/segment_aligner.sv
logic/word_assembler.sv
logic/jpeg_stream_packer.sv
bench/packer_tb.sv

// File: Makefile
TOOL  = verilator
FLAGS = --timing --assert
TOP   = packer_tb
FLIST = sources.f
BUILD = obj_dir
LOG   = sim.log
PASS  = ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
